//--- hw/wcache_pkg.sv
`default_nettype none

package wcache_pkg;

    // ========================================================================
    // Sizes
    // ========================================================================
    localparam int NUM_PORTS  = 4;                  // PE ports on the row
    localparam int ADDR_W     = 13;                 // Weight RAM address
    localparam int DATA_W     = 8;                  // One weight
    localparam int PORT_IDX_W = $clog2(NUM_PORTS);

    // ========================================================================
    // Payload types
    // ========================================================================
    typedef logic [NUM_PORTS-1:0] port_mask_t;      // One bit per port

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              last;
    } port_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } port_rsp_t;

    // Read address towards the weight RAM
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              last;
    } wram_req_t;

    // ========================================================================
    // Control encodings
    // ========================================================================
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CFG,
        ST_WORK,
        ST_DRAIN
    } wcache_state_e;

    typedef enum logic {
        MODE_CACHE,
        MODE_BYPASS
    } wcache_mode_e;

endpackage

`default_nettype wire

//--- hw/wcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module wcache_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cfg_valid,
    input  logic                     cfg_bypass,
    output logic                     cfg_ready,
    input  logic                     rd_busy,
    input  logic                     slots_empty,
    output logic                     work_en,
    output wcache_pkg::wcache_mode_e mode,
    output logic                     clear
);
    import wcache_pkg::*;

    wcache_state_e state;
    wcache_state_e state_nxt;
    logic          byp_cfg;     // Bypass bit seen on the config transfer

    // ========================================================================
    // State machine
    // ========================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:  if (cfg_valid) state_nxt = ST_CFG;
            ST_CFG:   state_nxt = ST_WORK;
            ST_WORK:  if (cfg_valid) state_nxt = ST_DRAIN;    // Reconfig request
            ST_DRAIN: if (!rd_busy && slots_empty) state_nxt = ST_IDLE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Mode is taken on the way into WORK
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byp_cfg <= 1'b0;
            mode    <= MODE_CACHE;
        end else begin
            if (cfg_valid && cfg_ready) begin
                byp_cfg <= cfg_bypass;
            end
            if (state == ST_CFG) begin
                mode <= byp_cfg ? MODE_BYPASS : MODE_CACHE;
            end
        end
    end

    assign cfg_ready = (state == ST_IDLE);
    assign clear     = (state == ST_IDLE);   // Last register and RR pointer
    assign work_en   = (state == ST_WORK);

    // Nothing in flight while a new configuration can be taken
    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_ready |-> !rd_busy && slots_empty);

endmodule

`default_nettype wire

//--- hw/wcache_port_arb.sv
`timescale 1ns/1ps
`default_nettype none

module wcache_port_arb (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              clear,
    input  wcache_pkg::port_mask_t                            req_valid,
    input  wcache_pkg::port_req_t [wcache_pkg::NUM_PORTS-1:0] req,
    input  wcache_pkg::port_mask_t                            port_open,
    input  wcache_pkg::port_mask_t                            hit,
    output logic                                              wram_req_valid,
    input  logic                                              wram_req_ready,
    output wcache_pkg::wram_req_t                             wram_req,
    input  logic                                              wram_rsp_valid,
    input  logic                                              wram_rsp_ready,
    output wcache_pkg::port_mask_t                            mc_take,
    output wcache_pkg::port_mask_t                            mc_mask,
    output logic                                              rd_busy,
    output logic                                              rd_done,
    output logic [wcache_pkg::ADDR_W-1:0]                     rd_addr
);
    import wcache_pkg::*;

    port_mask_t            cand;        // Open, valid and missing
    port_mask_t            match;       // Candidates on the granted address
    port_mask_t            grant_oh;
    logic [PORT_IDX_W-1:0] sel_idx;
    logic                  sel_found;
    logic [PORT_IDX_W-1:0] last_grant;
    logic                  lock_q;      // Grant held while the RAM stalls
    logic [PORT_IDX_W-1:0] lock_idx;
    logic                  rd_pend;
    logic                  req_xfer;

    assign cand = req_valid & port_open & ~hit;

    // ========================================================================
    // Round-robin pick starting after the previous grant
    // ========================================================================
    always_comb begin
        sel_idx   = lock_q ? lock_idx : last_grant;
        sel_found = lock_q;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            if (!sel_found && cand[PORT_IDX_W'(last_grant + k)]) begin
                sel_idx   = PORT_IDX_W'(last_grant + k);
                sel_found = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            match[i] = cand[i] && (req[i].addr == req[sel_idx].addr);
        end
    end

    assign grant_oh       = port_mask_t'(sel_found) << sel_idx;
    assign wram_req_valid = sel_found && !rd_pend;   // One read in flight
    assign wram_req.addr  = req[sel_idx].addr;
    assign wram_req.last  = req[sel_idx].last;
    assign req_xfer       = wram_req_valid && wram_req_ready;

    // Granted port always rides along, even if drain closed it meanwhile
    assign mc_take = req_xfer ? (match | grant_oh) : '0;
    assign rd_done = wram_rsp_valid && wram_rsp_ready;
    assign rd_busy = rd_pend || wram_req_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lock_q   <= 1'b0;
            lock_idx <= '0;
        end else begin
            lock_q   <= wram_req_valid && !wram_req_ready;
            lock_idx <= sel_idx;
        end
    end

    // ========================================================================
    // Outstanding read
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend    <= 1'b0;
            mc_mask    <= '0;
            last_grant <= '0;
        end else begin
            if (req_xfer) begin
                rd_pend    <= 1'b1;
                mc_mask    <= mc_take;
                last_grant <= sel_idx;
            end else if (rd_done) begin
                rd_pend <= 1'b0;
                mc_mask <= '0;
            end
            if (clear) begin
                last_grant <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_xfer) begin
            rd_addr <= wram_req.addr;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wram_req_valid && !wram_req_ready |=> wram_req_valid && $stable(wram_req));

    // RAM data only arrives for the read in flight
    a_rsp_pending: assert property (@(posedge clk) disable iff (!rst_n)
        wram_rsp_valid |-> rd_pend);

endmodule

`default_nettype wire

//--- hw/wcache_last_hit.sv
`timescale 1ns/1ps
`default_nettype none

module wcache_last_hit (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              clear,
    input  wcache_pkg::wcache_mode_e                          mode,
    input  logic                                              work_en,
    input  wcache_pkg::port_mask_t                            req_valid,
    input  wcache_pkg::port_req_t [wcache_pkg::NUM_PORTS-1:0] req,
    input  wcache_pkg::port_mask_t                            port_open,
    input  logic                                              rd_done,
    input  logic [wcache_pkg::ADDR_W-1:0]                     rd_addr,
    input  logic [wcache_pkg::DATA_W-1:0]                     wram_rsp_data,
    output wcache_pkg::port_mask_t                            hit,
    output wcache_pkg::port_mask_t                            hit_take,
    output logic [wcache_pkg::DATA_W-1:0]                     last_data
);
    import wcache_pkg::*;

    logic              last_vld;
    logic [ADDR_W-1:0] last_addr;

    // ========================================================================
    // Last RAM access
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_vld <= 1'b0;
        end else if (clear) begin
            last_vld <= 1'b0;
        end else if (rd_done) begin
            last_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_done) begin
            last_addr <= rd_addr;
            last_data <= wram_rsp_data;
        end
    end

    // Per-port compare that never hits in bypass
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            hit[i] = work_en && (mode == MODE_CACHE) && last_vld &&
                     req_valid[i] && (req[i].addr == last_addr);
        end
    end

    assign hit_take = hit & port_open;      // Accepted on this edge

endmodule

`default_nettype wire

//--- hw/wcache_resp.sv
`timescale 1ns/1ps
`default_nettype none

module wcache_resp (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              work_en,
    input  wcache_pkg::port_mask_t                            hit_take,
    input  wcache_pkg::port_req_t [wcache_pkg::NUM_PORTS-1:0] req,
    input  logic [wcache_pkg::DATA_W-1:0]                     last_data,
    input  wcache_pkg::port_mask_t                            mc_take,
    input  wcache_pkg::port_mask_t                            mc_mask,
    input  logic                                              wram_rsp_valid,
    input  logic [wcache_pkg::DATA_W-1:0]                     wram_rsp_data,
    output logic                                              wram_rsp_ready,
    output wcache_pkg::port_mask_t                            req_ready,
    output wcache_pkg::port_mask_t                            rsp_valid,
    input  wcache_pkg::port_mask_t                            rsp_ready,
    output wcache_pkg::port_rsp_t [wcache_pkg::NUM_PORTS-1:0] rsp,
    output wcache_pkg::port_mask_t                            port_open,
    output logic                                              slots_empty
);
    import wcache_pkg::*;

    port_mask_t rsp_free;       // Empty, or read on this edge
    port_mask_t mc_load;        // RAM data lands in these ports
    port_mask_t miss_last;      // Last flag of each waiting miss

    assign rsp_free  = ~rsp_valid | rsp_ready;
    assign port_open = {NUM_PORTS{work_en}} & ~mc_mask & rsp_free;
    assign req_ready = hit_take | mc_take;

    // Take RAM data only when every multicast target has room
    assign wram_rsp_ready = (|mc_mask) && ((mc_mask & ~rsp_free) == '0);
    assign mc_load        = (wram_rsp_valid && wram_rsp_ready) ? mc_mask : '0;
    assign slots_empty    = ~|rsp_valid;

    // ========================================================================
    // Response registers
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= '0;
        end else begin
            rsp_valid <= (rsp_valid & ~rsp_ready) | hit_take | mc_load;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (mc_take[i]) begin
                miss_last[i] <= req[i].last;
            end
            if (hit_take[i]) begin
                rsp[i].data <= last_data;
                rsp[i].last <= req[i].last;
            end else if (mc_load[i]) begin
                rsp[i].data <= wram_rsp_data;   // Multicast steering
                rsp[i].last <= miss_last[i];
            end
        end
    end

    a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
        ((hit_take | mc_load) & ~rsp_free) == '0);

endmodule

`default_nettype wire

//--- hw/wcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module wcache_top (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              cfg_valid,
    input  logic                                              cfg_bypass,
    output logic                                              cfg_ready,
    input  wcache_pkg::port_mask_t                            req_valid,
    output wcache_pkg::port_mask_t                            req_ready,
    input  wcache_pkg::port_req_t [wcache_pkg::NUM_PORTS-1:0] req,
    output wcache_pkg::port_mask_t                            rsp_valid,
    input  wcache_pkg::port_mask_t                            rsp_ready,
    output wcache_pkg::port_rsp_t [wcache_pkg::NUM_PORTS-1:0] rsp,
    output logic                                              wram_req_valid,
    input  logic                                              wram_req_ready,
    output wcache_pkg::wram_req_t                             wram_req,
    input  logic                                              wram_rsp_valid,
    output logic                                              wram_rsp_ready,
    input  logic [wcache_pkg::DATA_W-1:0]                     wram_rsp_data
);
    import wcache_pkg::*;

    logic              work_en;
    logic              clear;
    wcache_mode_e      mode;
    port_mask_t        port_open;
    port_mask_t        hit;
    port_mask_t        hit_take;
    port_mask_t        mc_take;
    port_mask_t        mc_mask;
    logic              rd_busy;
    logic              rd_done;
    logic [ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0] last_data;
    logic              slots_empty;

    // ========================================================================
    // Control and datapath
    // ========================================================================
    wcache_ctrl ctrl_inst (
        .clk, .rst_n, .cfg_valid, .cfg_bypass, .cfg_ready,
        .rd_busy, .slots_empty, .work_en, .mode, .clear
    );

    wcache_last_hit last_hit_inst (
        .clk, .rst_n, .clear, .mode, .work_en, .req_valid, .req,
        .port_open, .rd_done, .rd_addr, .wram_rsp_data,
        .hit, .hit_take, .last_data
    );

    wcache_port_arb port_arb_inst (
        .clk, .rst_n, .clear, .req_valid, .req, .port_open, .hit,
        .wram_req_valid, .wram_req_ready, .wram_req,
        .wram_rsp_valid, .wram_rsp_ready,
        .mc_take, .mc_mask, .rd_busy, .rd_done, .rd_addr
    );

    wcache_resp resp_inst (
        .clk, .rst_n, .work_en, .hit_take, .req, .last_data,
        .mc_take, .mc_mask, .wram_rsp_valid, .wram_rsp_data, .wram_rsp_ready,
        .req_ready, .rsp_valid, .rsp_ready, .rsp, .port_open, .slots_empty
    );

endmodule

`default_nettype wire

//--- dv/wcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wcache_tb;
    import wcache_pkg::*;

    localparam int BYPASS_REQS    = 120;
    localparam int CACHE_REQS     = 240;
    localparam int POOL_SIZE      = 6;      // Small pool so repeats and multicasts happen
    localparam int TIMEOUT_CYCLES = (BYPASS_REQS + CACHE_REQS) * 20 + 500;

    logic                      clk;
    logic                      rst_n;
    logic                      cfg_valid;
    logic                      cfg_bypass;
    logic                      cfg_ready;
    port_mask_t                req_valid;
    port_mask_t                req_ready;
    port_req_t [NUM_PORTS-1:0] req;
    port_mask_t                rsp_valid;
    port_mask_t                rsp_ready;
    port_rsp_t [NUM_PORTS-1:0] rsp;
    logic                      wram_req_valid;
    logic                      wram_req_ready;
    wram_req_t                 wram_req;
    logic                      wram_rsp_valid;
    logic                      wram_rsp_ready;
    logic [DATA_W-1:0]         wram_rsp_data;

    int                seed        = 32'h134d;
    int                errors      = 0;
    int                issued      = 0;
    int                quota       = 0;    // New requests still allowed in this phase
    int                outstanding = 0;
    bit                cfg_seen    = 1'b0;
    bit                cfg_done    = 1'b0;
    bit                bypass_mode = 1'b0;
    port_rsp_t         exp_q [NUM_PORTS][$];
    port_rsp_t         exp_head [NUM_PORTS];
    int                exp_cnt [NUM_PORTS];
    logic [ADDR_W-1:0] ram_q [$];          // Addresses waiting for data
    int                ram_wait;
    logic [ADDR_W-1:0] last_ret_addr;
    bit                last_ret_vld;
    port_mask_t        ram_src;

    wcache_top wcache_top_inst (.*);

    // Weight stored at any RAM address
    function automatic logic [DATA_W-1:0] ram_weight(input logic [ADDR_W-1:0] addr);
        return addr[7:0] ^ 8'h5A;
    endfunction

    function automatic logic [ADDR_W-1:0] pool_addr(input int pick);
        return ADDR_W'(32'h0A3 + pick * 32'h2C5);
    endfunction

    function automatic int pick_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic count_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================================================
    // Stimulus
    // ========================================================================
    task automatic step_cycle(input bit stall_rsp);
        port_mask_t taken;
        bit         cfg_xfer;
        @(posedge clk);
        taken    = req_valid & req_ready;
        cfg_xfer = cfg_valid && cfg_ready;
        if (cfg_xfer) begin
            cfg_seen    = 1'b1;
            cfg_done    = 1'b1;
            bypass_mode = cfg_bypass;
        end
        #1;
        if (cfg_xfer) cfg_valid = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (taken[i]) req_valid[i] = 1'b0;
            if (!req_valid[i] && quota > 0 && pick_below(2) == 1) begin
                req_valid[i] = 1'b1;
                req[i].addr  = pool_addr(pick_below(POOL_SIZE));
                req[i].last  = 1'(pick_below(2));
                quota--;
                issued++;
            end
        end
        rsp_ready      = stall_rsp ? '0 : port_mask_t'($random(seed));
        wram_req_ready = pick_below(4) != 0;
    endtask

    task automatic run_traffic(input int count);
        quota = count;
        while (quota > 0) step_cycle(1'b0);
        while (req_valid != '0) step_cycle(1'b0);   // Let the last ones be taken
    endtask

    // Responses are held back around the config so the drain has work to do
    task automatic configure(input bit bypass);
        cfg_done = 1'b0;
        repeat (3) step_cycle(1'b1);
        cfg_valid  = 1'b1;
        cfg_bypass = bypass;
        repeat (3) step_cycle(1'b1);
        while (!cfg_done) step_cycle(1'b0);
    endtask

    initial begin
        rst_n          = 1'b0;
        cfg_valid      = 1'b0;
        cfg_bypass     = 1'b0;
        req_valid      = '0;
        req            = '0;
        rsp_ready      = '0;
        wram_req_ready = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        quota = NUM_PORTS;          // Requests wait at the ports before the first config
        configure(1'b1);
        run_traffic(BYPASS_REQS);
        configure(1'b0);            // Back to cache mode
        run_traffic(CACHE_REQS);
        while (outstanding != 0) step_cycle(1'b0);
        repeat (4) step_cycle(1'b0);
        $display("Run done: %0d requests, %0d errors", issued, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, traffic did not complete", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    // ========================================================================
    // RAM model and scoreboard
    // ========================================================================
    initial begin : ram_model
        logic [ADDR_W-1:0] addr_in;
        bit                addr_xfer;
        bit                data_xfer;
        wram_rsp_valid = 1'b0;
        wram_rsp_data  = '0;
        ram_wait       = 0;
        last_ret_vld   = 1'b0;
        last_ret_addr  = '0;
        forever begin
            @(posedge clk);
            addr_xfer = wram_req_valid && wram_req_ready;
            data_xfer = wram_rsp_valid && wram_rsp_ready;
            addr_in   = wram_req.addr;
            if (cfg_valid && cfg_ready) last_ret_vld = 1'b0;
            #1;
            if (data_xfer) begin
                last_ret_addr  = ram_q.pop_front();
                last_ret_vld   = 1'b1;
                wram_rsp_valid = 1'b0;
            end
            if (addr_xfer) begin
                ram_q.push_back(addr_in);
                ram_wait = 1 + pick_below(6);   // 1 to 6 cycles
            end
            if (!wram_rsp_valid && ram_q.size() != 0) begin
                if (ram_wait > 1) begin
                    ram_wait--;
                end else begin
                    wram_rsp_valid = 1'b1;
                    wram_rsp_data  = ram_weight(ram_q[0]);
                end
            end
        end
    end

    initial begin : scoreboard
        port_rsp_t item;
        for (int i = 0; i < NUM_PORTS; i++) begin
            exp_cnt[i]  = 0;
            exp_head[i] = '0;
        end
        forever begin
            @(posedge clk);
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (rsp_valid[i] && rsp_ready[i] && exp_q[i].size() != 0) begin
                    void'(exp_q[i].pop_front());
                    outstanding--;
                end
                if (req_valid[i] && req_ready[i]) begin
                    item.data = ram_weight(req[i].addr);
                    item.last = req[i].last;
                    exp_q[i].push_back(item);
                    outstanding++;
                end
                exp_cnt[i]  = exp_q[i].size();
                exp_head[i] = (exp_cnt[i] != 0) ? exp_q[i][0] : '0;
            end
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================
    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !cfg_seen |-> cfg_ready && rsp_valid == '0 && req_ready == '0 &&
                      !wram_req_valid && !wram_rsp_ready)
        else count_error("DUT outputs were active before the first configuration");

    a_no_repeat: assert property (@(posedge clk) disable iff (!rst_n)
        wram_req_valid && wram_req_ready && !bypass_mode && last_ret_vld |->
            wram_req.addr != last_ret_addr)
        else count_error($sformatf("[ERROR] no_repeat_read: expected not %h, actual %h",
                                   $sampled(last_ret_addr), $sampled(wram_req.addr)));

    a_bypass_rise: assert property (@(posedge clk) disable iff (!rst_n)
        bypass_mode && (rsp_valid & ~$past(rsp_valid)) != '0 |->
            $past(wram_rsp_valid && wram_rsp_ready))
        else count_error("Bypass response rose without a RAM data transfer before it");

    a_cfg_drained: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_valid && cfg_ready && cfg_seen |-> rsp_valid == '0 && outstanding == 0)
        else count_error("Configuration accepted before all responses drained");

    // Ports accepted with the same address and last flag as the RAM read
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            ram_src[i] = req_valid[i] && req_ready[i] && req[i].addr == wram_req.addr &&
                         req[i].last == wram_req.last;
        end
    end

    a_ram_source: assert property (@(posedge clk) disable iff (!rst_n)
        wram_req_valid && wram_req_ready |-> ram_src != '0)
        else count_error("RAM read matches no accepted request in address and last flag");

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_checks
        a_rsp_owned: assert property (@(posedge clk) disable iff (!rst_n)
            rsp_valid[p] && rsp_ready[p] |-> exp_cnt[p] != 0)
            else count_error($sformatf("Response on port %0d without a request", p));

        a_rsp_match: assert property (@(posedge clk) disable iff (!rst_n)
            rsp_valid[p] && rsp_ready[p] && exp_cnt[p] != 0 |-> rsp[p] == exp_head[p])
            else count_error($sformatf("[ERROR] rsp_match port %0d: expected %h, actual %h",
                                       p, $sampled(exp_head[p]), $sampled(rsp[p])));

        // Every idle port waiting on the read address rides along
        a_mc_ready: assert property (@(posedge clk) disable iff (!rst_n)
            wram_req_valid && wram_req_ready && req_valid[p] &&
            req[p].addr == wram_req.addr && exp_cnt[p] == 0 |-> req_ready[p])
            else count_error($sformatf("[ERROR] mc_ready port %0d: expected 1, actual %b",
                                       p, $sampled(req_ready[p])));

        a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
            rsp_valid[p] && !rsp_ready[p] |=> rsp_valid[p] && $stable(rsp[p]))
            else count_error($sformatf("Response on port %0d changed while stalled", p));
    end

endmodule

`default_nettype wire

//--- wcache_top.f
hw/wcache_pkg.sv
hw/wcache_ctrl.sv
hw/wcache_port_arb.sv
hw/wcache_last_hit.sv
hw/wcache_resp.sv
hw/wcache_top.sv
dv/wcache_tb.sv

//--- run.sh
#!/bin/sh
# Build the weight cache testbench with Verilator and run it
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module wcache_tb -f wcache_top.f -o Vwcache_tb \
    && ./obj_dir/Vwcache_tb > sim.log 2>&1 \
    || echo "Build or simulation ended with an error"

cat sim.log 2>/dev/null
grep -qs "^STATUS: PASS$" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
